// File: memStage.f
source/memMapPkg.sv
source/memAccessPkg.sv
source/storeAligner.sv
source/dataMemory.sv
source/loadExtractor.sv
source/memStage.sv
testbench/memStage_assert.sv
testbench/memStageChecker.sv
testbench/memStageTb.sv

// File: runSim.sh
#!/bin/sh
# Builds and runs the memory stage testbench with Verilator.
# Exit status is nonzero when the log reports a failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f memStage.f --top-module memStageTb \
	-Mdir obj_dir -o memStageSim > build.log 2>&1 ||
	{ cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/memStageSim > sim.log 2>&1 ||
	echo "simulation exited abnormally, tests failed" >> sim.log

cat sim.log

grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: source/dataMemory.sv
`timescale 1ns/1ps

module dataMemory #(
	parameter int depthWords = 4096
) (
	input logic clk,
	input logic reset,
	input logic [memMapPkg::laneCount-1:0] byteEnable,
	input logic [memMapPkg::wordWidth-1:0] laneData,
	input logic [memMapPkg::wordAddrBits-1:0] wordIndex,
	output logic [memMapPkg::wordWidth-1:0] memWord
);

	localparam int laneCount = memMapPkg::laneCount;
	localparam int laneWidth = memMapPkg::laneWidth;

	// depthWords is a power of two, so the index is just the low address bits.
	localparam int indexBits = $clog2(depthWords);

	logic [memMapPkg::wordWidth-1:0] words [depthWords];
	logic [indexBits-1:0] index;

	assign index = wordIndex[indexBits-1:0];

	// Loads see the array directly, with no read latency.
	assign memWord = words[index];

	// Reset wipes the whole array in one edge.
	// Otherwise only the enabled byte lanes of the addressed word change.
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int w = 0; w < depthWords; w++) begin
				words[w] <= '0;
			end
		end else begin
			for (int lane = 0; lane < laneCount; lane++) begin
				if (byteEnable[lane]) begin
					words[index][lane*laneWidth +: laneWidth] <=
						laneData[lane*laneWidth +: laneWidth];
				end
			end
		end
	end

endmodule

// File: source/loadExtractor.sv
`timescale 1ns/1ps

module loadExtractor (
	input logic [memMapPkg::wordWidth-1:0] memWord,
	input memAccessPkg::accessMode_t mode,
	input logic [memMapPkg::offsetBits-1:0] byteOffset,
	output logic [memMapPkg::wordWidth-1:0] readData
);

	localparam int wordWidth = memMapPkg::wordWidth;
	localparam int laneWidth = memMapPkg::laneWidth;
	localparam int halfWidth = 2 * laneWidth;

	logic [halfWidth-1:0] pickedHalf;
	logic [laneWidth-1:0] pickedByte;
	logic halfFill;
	logic byteFill;

	// Halfword by offset bit 1, byte by the full offset.
	assign pickedHalf = byteOffset[1] ? memWord[wordWidth-1:halfWidth] : memWord[halfWidth-1:0];
	assign pickedByte = memWord[int'(byteOffset)*laneWidth +: laneWidth];

	// The fill bit is the top bit of the picked value unless zero extension is asked for.
	assign halfFill = pickedHalf[halfWidth-1] & ~mode.zeroExtend;
	assign byteFill = pickedByte[laneWidth-1] & ~mode.zeroExtend;

	always_comb begin
		case (mode.size)
			memAccessPkg::sizeHalf: begin
				readData = {{(wordWidth-halfWidth){halfFill}}, pickedHalf};
			end
			memAccessPkg::sizeByte: begin
				readData = {{(wordWidth-laneWidth){byteFill}}, pickedByte};
			end
			default: begin
				// Word loads and size 3 both return the stored word as is.
				readData = memWord;
			end
		endcase
	end

endmodule

// File: source/memAccessPkg.sv
package memAccessPkg;

	// Access size as carried in the upper two bits of the mode.
	typedef enum logic [1:0] {
		sizeWord = 2'd0,
		sizeHalf = 2'd1,
		sizeByte = 2'd2,
		sizeNone = 2'd3 // Stores nothing and loads a full word.
	} accessSize_t;

	// Three bit access mode.
	// The low bit chooses zero extension over sign extension on loads.
	typedef struct packed {
		accessSize_t size;
		logic zeroExtend;
	} accessMode_t;

	// Everything the store side needs in one bundle.
	typedef struct packed {
		logic writeEnable;
		accessMode_t mode;
		memMapPkg::byteAddr_u addr;
		logic [memMapPkg::wordWidth-1:0] data;
	} storeReq_t;

endpackage

// File: source/memMapPkg.sv
package memMapPkg;

	// Data word and byte lane geometry.
	localparam int wordWidth = 32;
	localparam int laneCount = 4;
	localparam int laneWidth = wordWidth / laneCount;

	// Bits of a byte address that pick the lane inside a word.
	localparam int offsetBits = $clog2(laneCount);

	localparam int wordAddrBits = wordWidth - offsetBits;

	// Word number in the high bits, byte lane in the low bits.
	typedef struct packed {
		logic [wordAddrBits-1:0] wordAddr;
		logic [offsetBits-1:0] byteOffset;
	} splitAddr_t;

	// One byte address, seen either as a flat number or split into word and lane.
	typedef union packed {
		logic [wordWidth-1:0] raw;
		splitAddr_t split;
	} byteAddr_u;

endpackage

// File: source/memStage.sv
`timescale 1ns/1ps

module memStage #(
	parameter int depthWords = 4096
) (
	input logic clk,
	input logic reset,
	input memAccessPkg::accessMode_t mode,
	input memMapPkg::byteAddr_u addr,
	input logic writeEnable,
	input logic [memMapPkg::wordWidth-1:0] writeData,
	output logic [memMapPkg::wordWidth-1:0] readData
);

	memAccessPkg::storeReq_t storeReq;

	logic [memMapPkg::laneCount-1:0] byteEnable;
	logic [memMapPkg::wordWidth-1:0] laneData;
	logic [memMapPkg::wordAddrBits-1:0] wordIndex;
	logic [memMapPkg::wordWidth-1:0] memWord;

	// Bundle the store side for the aligner.
	assign storeReq = '{
		writeEnable: writeEnable,
		mode: mode,
		addr: addr,
		data: writeData
	};

	storeAligner storeAligner_i (
		.req(storeReq),
		.byteEnable(byteEnable),
		.laneData(laneData),
		.wordIndex(wordIndex)
	);

	dataMemory #(
		.depthWords(depthWords)
	) dataMemory_i (
		.clk(clk),
		.reset(reset),
		.byteEnable(byteEnable),
		.laneData(laneData),
		.wordIndex(wordIndex),
		.memWord(memWord)
	);

	// Loads read the same word the store side addresses.
	loadExtractor loadExtractor_i (
		.memWord(memWord),
		.mode(mode),
		.byteOffset(addr.split.byteOffset),
		.readData(readData)
	);

endmodule

// File: source/storeAligner.sv
`timescale 1ns/1ps

module storeAligner (
	input memAccessPkg::storeReq_t req,
	output logic [memMapPkg::laneCount-1:0] byteEnable,
	output logic [memMapPkg::wordWidth-1:0] laneData,
	output logic [memMapPkg::wordAddrBits-1:0] wordIndex
);

	localparam int laneCount = memMapPkg::laneCount;
	localparam int laneWidth = memMapPkg::laneWidth;
	localparam int halfWidth = 2 * laneWidth;
	localparam int halfLanes = laneCount / 2;

	// Enable patterns for the lowest lane and the low halfword.
	localparam logic [laneCount-1:0] firstLane = 1;
	localparam logic [laneCount-1:0] lowHalfLanes = {halfLanes{1'b1}};

	logic [memMapPkg::offsetBits-1:0] byteOffset;
	logic [laneCount-1:0] laneMask;
	logic storeActive;

	assign byteOffset = req.addr.split.byteOffset;
	assign wordIndex = req.addr.split.wordAddr; // Word number goes to the memory untouched.

	// Size 3 is a no-op store.
	assign storeActive = req.writeEnable && (req.mode.size != memAccessPkg::sizeNone);

	// Lane selection and data replication by access size.
	always_comb begin
		laneMask = '0;
		laneData = req.data;
		case (req.mode.size)
			memAccessPkg::sizeWord: begin
				laneMask = '1;
			end
			memAccessPkg::sizeHalf: begin
				// Offset bit 1 picks the upper or lower halfword; bit 0 is ignored.
				laneData = {2{req.data[halfWidth-1:0]}};
				if (byteOffset[1]) begin
					laneMask = lowHalfLanes << halfLanes;
				end else begin
					laneMask = lowHalfLanes;
				end
			end
			memAccessPkg::sizeByte: begin
				laneData = {laneCount{req.data[laneWidth-1:0]}};
				laneMask = firstLane << byteOffset;
			end
			default: begin
				laneMask = '0;
			end
		endcase
	end

	// Nothing reaches the memory unless a real store is requested.
	assign byteEnable = storeActive ? laneMask : '0;

endmodule

// File: testbench/memStageChecker.sv
`timescale 1ns/1ps

module memStageChecker #(
	parameter int depthWords = 256
) (
	input logic clk,
	input logic reset,
	input memAccessPkg::accessMode_t mode,
	input memMapPkg::byteAddr_u addr,
	input logic writeEnable,
	input logic [31:0] writeData,
	input logic [31:0] readData,
	output logic ready,
	output int checkCount,
	output int errorCount
);

	logic [31:0] shadow [depthWords];
	logic [31:0] expected;
	logic cleared = 1'b0;
	int checks = 0;
	int errors = 0;

	assign ready = cleared; // Shadow holds known contents only after a reset edge.
	assign checkCount = checks;
	assign errorCount = errors;

	function automatic int wordSlot(input memMapPkg::byteAddr_u a);
		return int'(a.split.wordAddr) % depthWords;
	endfunction

	// Load value from the access rules: pick the lane or halfword, then extend it.
	function automatic logic [31:0] expectedLoad(input logic [31:0] word,
			input memAccessPkg::accessMode_t m, input logic [1:0] offset);
		logic [15:0] half;
		logic [7:0] lane;
		half = offset[1] ? word[31:16] : word[15:0];
		lane = word[int'(offset)*8 +: 8];
		case (m.size)
			memAccessPkg::sizeHalf: return m.zeroExtend ? {16'h0, half} : {{16{half[15]}}, half};
			memAccessPkg::sizeByte: return m.zeroExtend ? {24'h0, lane} : {{24{lane[7]}}, lane};
			default: return word;
		endcase
	endfunction

	// Word after a store, with the untouched lanes kept.
	function automatic logic [31:0] storedWord(input logic [31:0] old,
			input memAccessPkg::accessMode_t m, input logic [1:0] offset, input logic [31:0] data);
		logic [31:0] word;
		word = old;
		case (m.size)
			memAccessPkg::sizeWord: word = data;
			memAccessPkg::sizeHalf: begin
				if (offset[1]) word[31:16] = data[15:0];
				else word[15:0] = data[15:0];
			end
			memAccessPkg::sizeByte: word[int'(offset)*8 +: 8] = data[7:0];
			default: word = old; // Size 3 writes nothing.
		endcase
		return word;
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			for (int w = 0; w < depthWords; w++) shadow[w] = '0;
			cleared = 1'b1;
		end else if (cleared && writeEnable) begin
			shadow[wordSlot(addr)] = storedWord(shadow[wordSlot(addr)], mode,
				addr.split.byteOffset, writeData);
		end
	end

	// The load is compared in the middle of each cycle, once the inputs have settled.
	always @(negedge clk) begin
		if (cleared && !reset) begin
			expected = expectedLoad(shadow[wordSlot(addr)], mode, addr.split.byteOffset);
			checks++;
			if (readData !== expected) begin
				errors++;
				$display("ERROR %0t: readData expected %08h actual %08h addr %08h mode %b",
					$time, expected, readData, addr.raw, mode);
			end
		end
	end

endmodule

// File: testbench/memStageTb.sv
`timescale 1ns/1ps

module memStageTb;

	localparam int depthWords = 256;
	localparam int randomCycles = 2000;
	localparam int waitLimit = 50;

	logic clk = 1'b0;
	logic reset;
	memAccessPkg::accessMode_t mode;
	memMapPkg::byteAddr_u addr;
	logic writeEnable;
	logic [31:0] writeData;
	logic [31:0] readData;
	logic ready;
	int checkCount;
	int errorCount;
	logic timedOut = 1'b0;
	logic [31:0] a;
	logic [31:0] w;

	always #4 clk = ~clk;

	memStage #(
		.depthWords(depthWords)
	) memStage_i (
		.clk(clk),
		.reset(reset),
		.mode(mode),
		.addr(addr),
		.writeEnable(writeEnable),
		.writeData(writeData),
		.readData(readData)
	);

	memStageChecker #(
		.depthWords(depthWords)
	) checker_i (
		.clk(clk),
		.reset(reset),
		.mode(mode),
		.addr(addr),
		.writeEnable(writeEnable),
		.writeData(writeData),
		.readData(readData),
		.ready(ready),
		.checkCount(checkCount),
		.errorCount(errorCount)
	);

	// One access per cycle, applied 1 ns after the rising edge.
	task automatic driveAccess(input logic we, input logic [1:0] size, input logic zext,
			input logic [31:0] address, input logic [31:0] data);
		@(posedge clk);
		#1;
		writeEnable = we;
		mode.size = memAccessPkg::accessSize_t'(size);
		mode.zeroExtend = zext;
		addr.raw = address;
		writeData = data;
	endtask

	task automatic waitReady();
		int cycles;
		cycles = 0;
		while (!ready && cycles < waitLimit) begin
			@(posedge clk);
			cycles++;
		end
		if (!ready) begin
			$display("Timeout: the checker never saw the memory reset.");
			timedOut = 1'b1;
		end
	endtask

	// Waits until the checker has compared the last driven access.
	task automatic waitLastCheck();
		int cycles;
		int target;
		cycles = 0;
		target = checkCount + 1;
		while (checkCount < target && cycles < waitLimit) begin
			@(posedge clk);
			cycles++;
		end
		if (checkCount < target) begin
			$display("Timeout: the final access was never compared.");
			timedOut = 1'b1;
		end
	endtask

	initial begin
		void'($urandom(32'h54f630ce));
		reset = 1'b1;
		writeEnable = 1'b0;
		mode = '0;
		addr = '0;
		writeData = '0;
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;
		waitReady();
		if (!timedOut) begin
			repeat (40) driveAccess(1'b0, 2'($urandom), 1'($urandom), $urandom, $urandom);
			repeat (30) begin
				a = $urandom;
				driveAccess(1'b1, 2'd0, 1'b0, a, $urandom);
				driveAccess(1'b0, 2'd0, 1'b0, {a[31:2], 2'($urandom)}, $urandom);
			end
			// Partial stores over a known word, then the whole word is read back.
			repeat (40) begin
				a = $urandom;
				driveAccess(1'b1, 2'd0, 1'b0, a, $urandom);
				driveAccess(1'b1, 2'($urandom_range(1, 2)), 1'b0, {a[31:2], 2'($urandom)},
					$urandom);
				driveAccess(1'b0, 2'd0, 1'b0, a, $urandom);
			end
			// Both sign bits set and clear across the lanes.
			for (int i = 0; i < 32; i++) begin
				w = (i % 2 == 0) ? 32'h807f_ff01 : $urandom;
				a = $urandom;
				driveAccess(1'b1, 2'd0, 1'b0, a, w);
				for (int k = 0; k < 16; k++) begin
					driveAccess(1'b0, 2'(1 + k / 8), 1'(k / 4), {a[31:2], 2'(k)}, $urandom);
				end
			end
			repeat (20) begin
				a = $urandom;
				w = $urandom;
				driveAccess(1'b1, 2'd0, 1'b0, a, w);
				driveAccess(1'b1, 2'd3, 1'b0, a, ~w);
				driveAccess(1'b0, 2'd0, 1'b0, a, ~w);
				driveAccess(1'b0, 2'($urandom), 1'b0, a, ~w);
				driveAccess(1'b0, 2'd0, 1'b0, a, $urandom);
			end
			repeat (randomCycles) begin
				driveAccess(1'($urandom), 2'($urandom), 1'($urandom), $urandom, $urandom);
			end
			waitLastCheck();
		end
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0 && !timedOut && checkCount > 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: testbench/memStage_assert.sv
`timescale 1ns/1ps

module memStage_assert (
	input logic clk,
	input logic reset,
	input logic writeEnable,
	input memAccessPkg::accessMode_t mode,
	input logic [3:0] byteEnable,
	input logic [31:0] memWord
);

	noStoreNoEnable: assert property (@(posedge clk)
		(!writeEnable || mode.size == memAccessPkg::sizeNone) |-> byteEnable == 4'b0000)
		else $error("byteEnable set without an active store");

	byteOneLane: assert property (@(posedge clk)
		(writeEnable && mode.size == memAccessPkg::sizeByte) |-> $onehot(byteEnable))
		else $error("byte store does not enable exactly one lane");

	halfTwoLanes: assert property (@(posedge clk)
		(writeEnable && mode.size == memAccessPkg::sizeHalf)
		|-> (byteEnable == 4'b0011 || byteEnable == 4'b1100))
		else $error("halfword store enables the wrong lanes");

	// Any word read right after a reset edge is zero.
	clearedAfterReset: assert property (@(posedge clk) reset |=> memWord == 32'h0)
		else $error("memory word not cleared by reset");

endmodule

// Watches the aligner's enables and the memory word inside the top level.
bind memStage memStage_assert memStageAssert_i (
	.clk(clk),
	.reset(reset),
	.writeEnable(writeEnable),
	.mode(mode),
	.byteEnable(byteEnable),
	.memWord(memWord)
);
